//--- project.f
+incdir+include
source/alpha_pkg.sv
source/button_pickoff.sv
source/bias_register_file.sv
source/readout_sequencer.sv
source/legacy_serial_loader.sv
source/alpha_control_top.sv
bench/alpha_control_checks.sv
bench/alpha_control_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the alpha control testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"
mkdir -p "$build_dir"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module alpha_control_tb \
	-Mdir "$build_dir" -o alpha_control_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"$build_dir/alpha_control_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "All checks passed" "$log_file"; then
	exit 0
fi
echo "pass line not found in $log_file"
exit 1

//--- bench/alpha_control_tb.sv
`timescale 1ns/1ps
`include "alpha_params.svh"

module alpha_control_tb;
	localparam int T = `ALPHA_TIMING_CONSTANT;
	localparam int S = `ALPHA_SERIAL_STEP;
	localparam int READOUT_LIMIT = 11 * T + `ALPHA_ADC_CONVERSION_TIME + 100;
	localparam int WORD_LIMIT = 70 * S; // one word is 62S
	localparam int WATCH_READOUT = 0;
	localparam int WATCH_WORDS = 1;
	localparam int WATCH_BITS = 2;
	localparam int WATCH_PCLK_LOW = 3;

	logic clock = 1'b0;
	logic reset;
	logic [1:0] button;
	logic [3:0] isel_select;
	logic trig_bottom_enable;
	logic [3:0] led;
	logic dreset, sync, token_a, trig_top, trig_bottom;
	logic sin, sclk_pin, pclk_pin;
	logic [1:0] start_probe;
	logic readout_done;
	int error_count, word_count, bit_count;
	int timeouts, tests_run, tests_failed, failures_before;

	always #5 clock = ~clock; // 10 ns

	alpha_control_top i_alpha_control_top (
		.clock(clock), .reset(reset), .button(button), .isel_select(isel_select),
		.trig_bottom_enable(trig_bottom_enable), .led(led), .dreset(dreset), .sync(sync),
		.token_a(token_a), .trig_top(trig_top), .trig_bottom(trig_bottom), .sin(sin),
		.sclk_pin(sclk_pin), .pclk_pin(pclk_pin)
	);

	assign start_probe = i_alpha_control_top.start; // pickoff pulses

	alpha_control_checks i_alpha_control_checks (
		.clock(clock), .reset(reset), .button(button), .start(start_probe),
		.isel_select(isel_select), .trig_bottom_enable(trig_bottom_enable), .led(led),
		.dreset(dreset), .sync(sync), .token_a(token_a), .trig_top(trig_top),
		.trig_bottom(trig_bottom), .sin(sin), .sclk_pin(sclk_pin), .pclk_pin(pclk_pin),
		.error_count(error_count), .readout_done(readout_done),
		.word_count(word_count), .bit_count(bit_count)
	);

	function automatic int watched(input int what);
		case (what)
			WATCH_READOUT: return int'(readout_done);
			WATCH_WORDS: return word_count;
			WATCH_BITS: return bit_count;
			default: return int'(!pclk_pin);
		endcase
	endfunction

	// skipped once any wait has timed out
	task automatic wait_for(input int what, input int target, input int limit, input string label);
		int waited;
		waited = 0;
		while (timeouts == 0 && watched(what) < target && waited < limit) begin
			@(negedge clock);
			waited++;
		end
		if (timeouts == 0 && watched(what) < target) begin
			$display("Timeout: %s did not happen within %0d cycles", label, limit);
			timeouts++;
		end
	endtask

	task automatic press(input logic which);
		@(negedge clock);
		button[which] = 1'b1;
		repeat (20) @(negedge clock); // held well past the pickoff depth
		button[which] = 1'b0;
	endtask

	task automatic finish_load();
		wait_for(WATCH_WORDS, 4, 4 * WORD_LIMIT, "fourth serial word");
		wait_for(WATCH_PCLK_LOW, 1, 12 * S, "last pclk fall");
		repeat (2 * S) @(negedge clock); // trailing step before idle
	endtask

	task automatic finish_test(input string name);
		int failures;
		failures = error_count + timeouts;
		tests_run++;
		if (failures == failures_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: FAILED, %0d new errors", tests_run, name,
				failures - failures_before);
			tests_failed++;
		end
		failures_before = failures;
	endtask

	initial begin
		void'($urandom(32'hacff));
		reset = 1'b1;
		button = 2'b00;
		isel_select = 4'h0;
		trig_bottom_enable = 1'b1;
		timeouts = 0;
		tests_run = 0;
		tests_failed = 0;
		failures_before = 0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		repeat (300) @(negedge clock); // quiet, nothing pressed
		finish_test("outputs idle after reset");

		press(1'b0);
		wait_for(WATCH_READOUT, 1, READOUT_LIMIT, "end of readout timeline");
		finish_test("readout timeline with dreset on the serial clocks");

		isel_select = 4'($urandom_range(15, 0));
		repeat (4) @(negedge clock);
		press(1'b1);
		finish_load();
		finish_test("serial bias words");

		trig_bottom_enable = 1'b0;
		press(1'b0);
		wait_for(WATCH_READOUT, 1, READOUT_LIMIT, "end of gated readout");
		finish_test("bottom trigger gated off");

		trig_bottom_enable = 1'b1;
		isel_select = 4'($urandom_range(15, 0));
		repeat (4) @(negedge clock);
		press(1'b1);
		wait_for(WATCH_WORDS, 1, WORD_LIMIT, "first word before restart");
		wait_for(WATCH_BITS, 5, 30 * S, "bits of word 1"); // latch, gap, then 5 bits
		press(1'b1); // lands in the middle of word 1
		finish_load();
		finish_test("serial load restart");

		$display("tests %0d, failed %0d, check errors %0d, timeouts %0d",
			tests_run, tests_failed, error_count, timeouts);
		if (tests_failed == 0 && error_count == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- bench/alpha_control_checks.sv
`timescale 1ns/1ps
`include "alpha_params.svh"

// reference checks for the control core, sampled on the rising clock
module alpha_control_checks (
	input  logic clock,
	input  logic reset,
	input  logic [1:0] button,
	input  logic [1:0] start, // pickoff outputs, probed inside the DUT
	input  logic [3:0] isel_select,
	input  logic trig_bottom_enable,
	input  logic [3:0] led,
	input  logic dreset,
	input  logic sync,
	input  logic token_a,
	input  logic trig_top,
	input  logic trig_bottom,
	input  logic sin,
	input  logic sclk_pin,
	input  logic pclk_pin,
	output int error_count,
	output logic readout_done, // final token has dropped
	output int word_count, // words latched since the last load start
	output int bit_count
);
	localparam int T = `ALPHA_TIMING_CONSTANT;
	localparam int S = `ALPHA_SERIAL_STEP;

	logic [3:0] levels;
	logic [3:0] last_levels;
	logic [3:0] last_select;
	logic [3:0] load_nibble; // selector at the load press
	logic [1:0] last_button;
	logic [15:0] shifted;
	logic last_reset;
	logic last_sclk;
	logic last_pclk;
	logic readout_active;
	logic load_seen;
	int cycle;
	int change_cycle;
	int edge_index; // level changes since the readout start
	int pclk_rise_cycle;
	int press_age [2]; // -1 when no press is pending

	assign levels = {dreset, sync, token_a, trig_top};

	// levels after each change of the timeline
	function automatic logic [3:0] expected_levels(input int n);
		case (n)
			1: return 4'b1000;
			3: return 4'b0100;
			5, 9: return 4'b0010; // both tokens
			7: return 4'b0001;
			default: return 4'b0000;
		endcase
	endfunction

	// cycles spent in the level before change n
	function automatic int expected_gap(input int n);
		if (n == 1) return T + 1; // lead-in after the start pulse
		if (n == 9) return T + `ALPHA_ADC_CONVERSION_TIME;
		return T;
	endfunction

	function automatic logic [15:0] expected_word(input int n, input logic [3:0] nibble);
		logic [3:0] top;
		top = (n == 1) ? nibble : 4'(`ALPHA_BIAS_DEFAULT_MSN); // word 1 is isel
		return {2'b00, 2'(n), top, 8'(`ALPHA_BIAS_LOW_BYTE)};
	endfunction

	task automatic mismatch(input string what);
		$display("Mismatch at %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic report_fault(input string what);
		$display("Error at %0t: %s", $time, what);
		error_count++;
	endtask

	// one start pulse per press, a few cycles after it
	task automatic track_press(input logic which);
		if (start[which]) begin
			assert (press_age[which] >= 0)
				else report_fault($sformatf("start %0d pulsed without a press", which));
			press_age[which] = -1;
		end else if (press_age[which] >= 0) begin
			press_age[which]++;
			assert (press_age[which] <= 12) else begin
				report_fault($sformatf("button %0d press gave no start pulse", which));
				press_age[which] = -1;
			end
		end
		if (button[which] && !last_button[which]) press_age[which] = 0;
	endtask

	always @(posedge clock) begin
		cycle++;
		if (reset) begin
			error_count = 0;
			readout_done = 1'b0;
			readout_active = 1'b0;
			load_seen = 1'b0;
			word_count = 0;
			bit_count = 0;
			edge_index = 0;
			change_cycle = 0;
			pclk_rise_cycle = -1;
			press_age[0] = -1;
			press_age[1] = -1;
			shifted = '0;
			load_nibble = '0;
		end else begin
			if (!last_reset) begin
				assert (led == last_select) // one cycle behind the selector
					else mismatch($sformatf("led %h, selector was %h", led, last_select));
			end
			track_press(1'b0);
			track_press(1'b1);
			if (start[0]) begin
				readout_active = 1'b1;
				readout_done = 1'b0;
				edge_index = 0;
				change_cycle = cycle;
			end else if (readout_active && levels != last_levels) begin
				edge_index++;
				assert (levels == expected_levels(edge_index))
					else mismatch($sformatf("change %0d levels %b, expected %b",
						edge_index, levels, expected_levels(edge_index)));
				assert (cycle - change_cycle == expected_gap(edge_index))
					else mismatch($sformatf("change %0d after %0d cycles, expected %0d",
						edge_index, cycle - change_cycle, expected_gap(edge_index)));
				change_cycle = cycle;
				if (edge_index == 10) begin
					readout_active = 1'b0;
					readout_done = 1'b1;
				end
			end
			assert (readout_active || levels == 4'b0000)
				else mismatch($sformatf("controls %b with no readout running", levels));
			if (dreset) begin
				assert (sclk_pin && pclk_pin) else mismatch("serial clocks low during dreset");
			end
			assert (trig_bottom == (trig_top & trig_bottom_enable))
				else mismatch($sformatf("trig_bottom %b, trig %b, enable %b",
					trig_bottom, trig_top, trig_bottom_enable));
			if (!load_seen) begin
				assert (!sin && ((!sclk_pin && !pclk_pin) || dreset))
					else mismatch("serial lines moved with no load started");
			end
			if (start[1]) begin
				load_seen = 1'b1; // restart drops any partial word
				word_count = 0;
				bit_count = 0;
				load_nibble = isel_select;
				pclk_rise_cycle = -1;
			end else if (!dreset) begin
				if (sclk_pin && !last_sclk) begin
					shifted = {shifted[14:0], sin}; // MSB arrives first
					bit_count++;
				end
				if (pclk_pin && !last_pclk) begin
					assert (bit_count == 16)
						else mismatch($sformatf("%0d bits before pclk", bit_count));
					assert (shifted == expected_word(word_count, load_nibble))
						else mismatch($sformatf("word %0d is %h, expected %h", word_count,
							shifted, expected_word(word_count, load_nibble)));
					word_count++;
					bit_count = 0;
					pclk_rise_cycle = cycle;
				end
				if (!pclk_pin && last_pclk && pclk_rise_cycle >= 0) begin
					assert (cycle - pclk_rise_cycle == 11 * S)
						else mismatch($sformatf("pclk high %0d cycles",
							cycle - pclk_rise_cycle));
					pclk_rise_cycle = -1;
				end
			end
		end
		last_reset = reset;
		last_select = isel_select;
		last_button = button;
		last_levels = levels;
		last_sclk = sclk_pin;
		last_pclk = pclk_pin;
	end

endmodule

//--- source/alpha_control_top.sv
`timescale 1ns/1ps
`include "alpha_params.svh"

// alpha test board control core
// button 0 runs the readout timeline, button 1 the serial bias load
module alpha_control_top (
	input  logic clock,
	input  logic reset,
	input  logic [`ALPHA_NUM_BUTTONS-1:0] button,
	input  logic [3:0] isel_select, // rotary selector
	input  logic trig_bottom_enable, // board switch
	output logic [3:0] led,
	output logic dreset,
	output logic sync,
	output logic token_a,
	output logic trig_top,
	output logic trig_bottom,
	output logic sin,
	output logic sclk_pin,
	output logic pclk_pin
);
	logic [`ALPHA_NUM_BUTTONS-1:0] start; // one pulse per press
	logic readout_start;
	logic load_start;
	alpha_pkg::bias_words_t bias_words;
	alpha_pkg::readout_controls_t controls;
	alpha_pkg::serial_lines_t lines;

	// one pickoff per button
	genvar i;
	generate
		for (i = 0; i < `ALPHA_NUM_BUTTONS; i++) begin : g_pickoff
			button_pickoff i_button_pickoff (
				.clock(clock),
				.reset(reset),
				.button(button[i]),
				.start(start[i])
			);
		end
	endgenerate

	assign readout_start = start[0];
	assign load_start = start[1];

	bias_register_file i_bias_register_file (
		.clock(clock),
		.reset(reset),
		.isel_select(isel_select),
		.bias_words(bias_words),
		.led(led)
	);

	readout_sequencer i_readout_sequencer (
		.clock(clock),
		.reset(reset),
		.readout_start(readout_start),
		.controls(controls)
	);

	legacy_serial_loader i_legacy_serial_loader (
		.clock(clock),
		.reset(reset),
		.load_start(load_start),
		.bias_words(bias_words),
		.lines(lines)
	);

	assign dreset = controls.dreset;
	assign sync = controls.sync;
	assign token_a = controls.token_a;
	assign trig_top = controls.trig;
	assign trig_bottom = controls.trig & trig_bottom_enable; // bottom copy gated by switch
	assign sin = lines.sin;
	// digital reset also pulses the serial clocks on the chip
	assign sclk_pin = lines.sclk | controls.dreset;
	assign pclk_pin = lines.pclk | controls.dreset;

endmodule

//--- source/legacy_serial_loader.sv
`timescale 1ns/1ps
`include "alpha_params.svh"

// legacy serial load of the four bias registers
// per bit: sin, S later sclk rises, S later sclk falls, S later next sin
// per word: 16 bits MSB first, 2S wait, pclk high 11S, S wait
module legacy_serial_loader (
	input  logic clock,
	input  logic reset,
	input  logic load_start, // one cycle, restarts a running load
	input  alpha_pkg::bias_words_t bias_words,
	output alpha_pkg::serial_lines_t lines
);
	localparam int S = `ALPHA_SERIAL_STEP;
	localparam int WORD_WIDTH = `ALPHA_SERIAL_WORD_WIDTH;
	localparam int STEP_WIDTH = $clog2(11 * S + 1); // longest step is the latch
	localparam int BIT_WIDTH = $clog2(WORD_WIDTH);

	// step counter values at which each event fires
	localparam logic [STEP_WIDTH-1:0] SIN_AT = STEP_WIDTH'(S - 1);
	localparam logic [STEP_WIDTH-1:0] SCLK_RISE_AT = STEP_WIDTH'(2 * S - 1);
	localparam logic [STEP_WIDTH-1:0] SCLK_FALL_AT = STEP_WIDTH'(3 * S - 1);
	localparam logic [STEP_WIDTH-1:0] LATCH_WAIT_END = STEP_WIDTH'(2 * S - 1);
	localparam logic [STEP_WIDTH-1:0] LATCH_END = STEP_WIDTH'(11 * S - 1);
	localparam logic [STEP_WIDTH-1:0] NEXT_WORD_END = STEP_WIDTH'(S - 1);
	localparam logic [BIT_WIDTH-1:0] FIRST_BIT = BIT_WIDTH'(WORD_WIDTH - 1);

	alpha_pkg::serial_step_e step;
	logic [STEP_WIDTH-1:0] count;
	logic [BIT_WIDTH-1:0] bit_index; // counts down, MSB first
	alpha_pkg::bias_address_e word_index;
	logic [`ALPHA_BIAS_WIDTH-1:0] bias_value;
	logic [WORD_WIDTH-1:0] word;

	// pick the value for the word being shifted
	always_comb begin
		case (word_index)
			alpha_pkg::addr_cmp_bias: bias_value = bias_words.cmp_bias;
			alpha_pkg::addr_isel: bias_value = bias_words.isel;
			alpha_pkg::addr_sb_bias: bias_value = bias_words.sb_bias;
			default: bias_value = bias_words.db_bias;
		endcase
	end

	assign word = {2'b00, word_index, bias_value}; // zeros, address, value

	always_ff @(posedge clock) begin
		if (reset) begin
			step <= alpha_pkg::step_idle;
			count <= '0;
			bit_index <= FIRST_BIT;
			word_index <= alpha_pkg::addr_cmp_bias;
			lines <= '0;
		end else if (load_start) begin
			// fresh load from word 0, lines low
			step <= alpha_pkg::step_shift;
			count <= '0;
			bit_index <= FIRST_BIT;
			word_index <= alpha_pkg::addr_cmp_bias;
			lines <= '0;
		end else begin
			if (step != alpha_pkg::step_idle) begin
				count <= count + 1'b1; // overridden at step boundaries
			end
			case (step)
				alpha_pkg::step_shift: begin
					if (count == SIN_AT) begin
						lines.sin <= word[bit_index];
					end else if (count == SCLK_RISE_AT) begin
						lines.sclk <= 1'b1; // chip samples sin here
					end else if (count == SCLK_FALL_AT) begin
						lines.sclk <= 1'b0;
						count <= '0;
						if (bit_index == '0) begin
							step <= alpha_pkg::step_latch_wait; // word fully shifted
						end else begin
							bit_index <= bit_index - 1'b1;
						end
					end
				end
				alpha_pkg::step_latch_wait: begin
					if (count == LATCH_WAIT_END) begin
						lines.pclk <= 1'b1;
						step <= alpha_pkg::step_latch;
						count <= '0;
					end
				end
				alpha_pkg::step_latch: begin
					if (count == LATCH_END) begin
						lines.pclk <= 1'b0; // register takes the word
						step <= alpha_pkg::step_next_word;
						count <= '0;
					end
				end
				alpha_pkg::step_next_word: begin
					if (count == NEXT_WORD_END) begin
						count <= '0;
						lines.sin <= 1'b0;
						if (word_index == alpha_pkg::addr_db_bias) begin
							step <= alpha_pkg::step_idle; // last word loaded
						end else begin
							word_index <= alpha_pkg::bias_address_e'(word_index + 2'd1);
							bit_index <= FIRST_BIT;
							step <= alpha_pkg::step_shift;
						end
					end
				end
				default: begin
					count <= '0; // idle, nothing running
				end
			endcase
		end
	end

endmodule

//--- source/readout_sequencer.sv
`timescale 1ns/1ps
`include "alpha_params.svh"

// readout timeline
// lead-in, dreset, sync, token, trig, conversion wait, final token
// every phase is T cycles long except convert
module readout_sequencer (
	input  logic clock,
	input  logic reset,
	input  logic readout_start, // one cycle, restarts a running timeline
	output alpha_pkg::readout_controls_t controls
);
	localparam int T = `ALPHA_TIMING_CONSTANT;
	localparam int CONVERT_LENGTH = `ALPHA_TIMING_CONSTANT + `ALPHA_ADC_CONVERSION_TIME;
	localparam int COUNT_WIDTH = $clog2(CONVERT_LENGTH + 1);

	alpha_pkg::readout_phase_e phase;
	alpha_pkg::readout_phase_e phase_next;
	logic [COUNT_WIDTH-1:0] count; // cycles spent in the current phase
	logic [COUNT_WIDTH-1:0] count_next;
	logic [COUNT_WIDTH-1:0] last_count;
	logic armed; // idle is running its lead-in
	logic armed_next;

	// output levels held during each phase
	function automatic alpha_pkg::readout_controls_t decode(input alpha_pkg::readout_phase_e p);
		alpha_pkg::readout_controls_t c;
		c = '0;
		case (p)
			alpha_pkg::phase_dreset: c.dreset = 1'b1;
			alpha_pkg::phase_sync: c.sync = 1'b1;
			alpha_pkg::phase_token: c.token_a = 1'b1;
			alpha_pkg::phase_trig: c.trig = 1'b1;
			alpha_pkg::phase_token_final: c.token_a = 1'b1; // second token after conversion
			default: c = '0;
		endcase
		return c;
	endfunction

	// convert is the only long phase
	assign last_count = (phase == alpha_pkg::phase_convert) ?
		COUNT_WIDTH'(CONVERT_LENGTH - 1) : COUNT_WIDTH'(T - 1);

	always_comb begin
		phase_next = phase;
		count_next = count;
		armed_next = armed;
		if (readout_start) begin
			// back to the start of the lead-in, outputs drop
			phase_next = alpha_pkg::phase_idle;
			count_next = '0;
			armed_next = 1'b1;
		end else if (armed || (phase != alpha_pkg::phase_idle)) begin
			if (count == last_count) begin
				count_next = '0;
				case (phase)
					alpha_pkg::phase_idle: begin
						phase_next = alpha_pkg::phase_dreset; // lead-in over
						armed_next = 1'b0;
					end
					alpha_pkg::phase_dreset: phase_next = alpha_pkg::phase_dreset_gap;
					alpha_pkg::phase_dreset_gap: phase_next = alpha_pkg::phase_sync;
					alpha_pkg::phase_sync: phase_next = alpha_pkg::phase_sync_gap;
					alpha_pkg::phase_sync_gap: phase_next = alpha_pkg::phase_token;
					alpha_pkg::phase_token: phase_next = alpha_pkg::phase_token_gap;
					alpha_pkg::phase_token_gap: phase_next = alpha_pkg::phase_trig;
					alpha_pkg::phase_trig: phase_next = alpha_pkg::phase_convert;
					alpha_pkg::phase_convert: phase_next = alpha_pkg::phase_token_final;
					alpha_pkg::phase_token_final: phase_next = alpha_pkg::phase_final_gap;
					default: phase_next = alpha_pkg::phase_idle; // final gap done
				endcase
			end else begin
				count_next = count + 1'b1;
			end
		end
	end

	// outputs change on the same edge as the phase
	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= alpha_pkg::phase_idle;
			count <= '0;
			armed <= 1'b0;
			controls <= '0;
		end else begin
			phase <= phase_next;
			count <= count_next;
			armed <= armed_next;
			controls <= decode(phase_next);
		end
	end

endmodule

//--- source/bias_register_file.sv
`timescale 1ns/1ps
`include "alpha_params.svh"

// bias values for the serial loader
// isel top nibble comes from the rotary selector, rest is fixed
module bias_register_file (
	input  logic clock,
	input  logic reset,
	input  logic [3:0] isel_select, // rotary selector, board pins
	output alpha_pkg::bias_words_t bias_words,
	output logic [3:0] led
);
	logic [3:0] isel_nibble; // registered selector

	// selector is sampled every clock, no debounce
	always_ff @(posedge clock) begin
		if (reset) begin
			isel_nibble <= 4'h0;
		end else begin
			isel_nibble <= isel_select;
		end
	end

	// value = top nibble then low byte
	always_comb begin
		bias_words.cmp_bias = {`ALPHA_BIAS_DEFAULT_MSN, `ALPHA_BIAS_LOW_BYTE};
		bias_words.isel = {isel_nibble, `ALPHA_BIAS_LOW_BYTE}; // tunable one
		bias_words.sb_bias = {`ALPHA_BIAS_DEFAULT_MSN, `ALPHA_BIAS_LOW_BYTE};
		bias_words.db_bias = {`ALPHA_BIAS_DEFAULT_MSN, `ALPHA_BIAS_LOW_BYTE};
	end

	assign led = isel_nibble; // operator sees the loaded nibble

endmodule

//--- source/button_pickoff.sv
`timescale 1ns/1ps
`include "alpha_params.svh"

// button press to single-cycle start pulse
// pipeline depth gives a crude settle time before the edge is taken
module button_pickoff (
	input  logic clock,
	input  logic reset,
	input  logic button,
	output logic start
);
	localparam int PICKOFF = `ALPHA_BUTTON_PICKOFF;

	logic [PICKOFF:0] pipeline; // bit 0 newest, bit PICKOFF oldest

	always_ff @(posedge clock) begin
		if (reset) begin
			pipeline <= '0;
			start <= 1'b0;
		end else begin
			pipeline <= {pipeline[PICKOFF-1:0], button}; // shift toward the tap
			// low in the oldest stage, high in the next one
			// so only a rising press fires, never a release
			start <= (pipeline[PICKOFF:PICKOFF-1] == 2'b01);
		end
	end

endmodule

//--- source/alpha_pkg.sv
`include "alpha_params.svh"

package alpha_pkg;

	// four bias values, in serial load order
	typedef struct packed {
		logic [`ALPHA_BIAS_WIDTH-1:0] cmp_bias;
		logic [`ALPHA_BIAS_WIDTH-1:0] isel;
		logic [`ALPHA_BIAS_WIDTH-1:0] sb_bias;
		logic [`ALPHA_BIAS_WIDTH-1:0] db_bias;
	} bias_words_t;

	// readout control levels to the chip
	typedef struct packed {
		logic dreset; // digital reset
		logic sync;
		logic token_a;
		logic trig;
	} readout_controls_t;

	// legacy serial lines
	typedef struct packed {
		logic sin; // data, MSB first
		logic sclk; // shift clock
		logic pclk; // parallel latch
	} serial_lines_t;

	// register address, also the word index
	typedef enum logic [1:0] {
		addr_cmp_bias = 2'd0,
		addr_isel = 2'd1,
		addr_sb_bias = 2'd2,
		addr_db_bias = 2'd3
	} bias_address_e;

	// readout timeline phases
	typedef enum logic [3:0] {
		phase_idle, // also the lead-in once armed
		phase_dreset,
		phase_dreset_gap,
		phase_sync,
		phase_sync_gap,
		phase_token,
		phase_token_gap,
		phase_trig,
		phase_convert, // long adc wait
		phase_token_final,
		phase_final_gap
	} readout_phase_e;

	// serial loader steps
	typedef enum logic [2:0] {
		step_idle,
		step_shift, // one bit per 3 steps
		step_latch_wait,
		step_latch, // pclk high
		step_next_word
	} serial_step_e;

endpackage

//--- include/alpha_params.svh
`ifndef ALPHA_PARAMS_SVH
`define ALPHA_PARAMS_SVH

// readout timeline, in clock cycles
`define ALPHA_TIMING_CONSTANT 100 // one readout phase
`define ALPHA_ADC_CONVERSION_TIME 8192 // added to the convert phase

// legacy serial interface, in clock cycles
`define ALPHA_SERIAL_STEP 50 // sin to sclk spacing
`define ALPHA_SERIAL_WORD_WIDTH 16 // zeros, address, value

// button pipeline tap
// pipeline is one stage deeper than this index
`define ALPHA_BUTTON_PICKOFF 6

// bias words
`define ALPHA_BIAS_WIDTH 12
`define ALPHA_BIAS_DEFAULT_MSN 4'h8 // cmp, sb and db top nibble
`define ALPHA_BIAS_LOW_BYTE 8'h44 // shared by all four biases

// start buttons
// 0 readout, 1 serial load
`define ALPHA_NUM_BUTTONS 2

`endif
